// File: Makefile
# Verilator build and run for the io_reader testbench
# any variable below can be overridden on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP ?= io_reader_tb
FLIST ?= io_reader.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: io_reader.f
+incdir+source
source/job_pkg.sv
source/burst_pkg.sv
source/job_if.sv
source/job_admit.sv
source/work_queue.sv
source/burst_issuer.sv
source/lane_router.sv
source/io_reader_top.sv
verif/io_reader_tb.sv

// File: source/burst_issuer.sv
// read burst issuer
// takes the work queue head, requests up to one 4 KB burst of it and pushes
// the rest of the job back; the job id of every issued burst goes into
// a tag fifo that the lane router pops at the end of each burst
`timescale 1ns/1ns
`include "io_reader_defines.svh"
`default_nettype none

module burst_issuer (
	input logic clk,
	input logic rst_n,
	input logic start_i,
	job_if.dst head_q,
	job_if.src push_q,
	output logic rd_req_o,
	input logic rd_req_ack_i,
	output logic [7:0] rd_len_o,
	output logic [63:0] rd_addr_o,
	output burst_pkg::tag_t tag_o,
	output logic tag_valid_o,
	input logic tag_pop_i,
	output logic tags_empty_o
);

	localparam int TAG_AW = $clog2(`IOR_TAG_DEPTH);
	localparam logic [63:0] BURST_BYTES = 64'(`IOR_BURST_BEATS * `IOR_BEAT_BYTES);

	burst_pkg::rd_state_e rd_state;
	burst_pkg::tag_t tag_mem [`IOR_TAG_DEPTH];
	logic [TAG_AW-1:0] tag_wr_ptr;
	logic [TAG_AW-1:0] tag_rd_ptr;
	logic [TAG_AW:0] tag_count;
	logic tag_rd;
	logic tag_afull;
	logic take;
	logic rd_req_r;
	logic push_valid_r;
	logic [7:0] rd_len_r;
	logic [63:0] rd_addr_r;
	job_pkg::job_t push_job_r;

	assign take = (rd_state == burst_pkg::RD_CHECK) & head_q.valid;
	assign head_q.ready = take; // pop pulse
	assign tag_rd = tag_pop_i & (tag_count != '0);
	assign tag_afull = (tag_count >= `IOR_TAG_AFULL);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state <= burst_pkg::RD_START;
			rd_req_r <= 1'b0;
			push_valid_r <= 1'b0;
		end else begin
			if (push_valid_r && push_q.ready) begin
				push_valid_r <= 1'b0;
			end
			case (rd_state)
				burst_pkg::RD_START: begin
					if (start_i) begin
						rd_state <= burst_pkg::RD_CHECK;
					end
				end
				burst_pkg::RD_CHECK: begin
					if (head_q.valid) begin
						rd_req_r <= 1'b1;
						push_valid_r <= (head_q.job.beats > `IOR_BURST_BEATS);
						rd_state <= burst_pkg::RD_PROCESS;
					end
				end
				burst_pkg::RD_PROCESS: begin
					if (rd_req_ack_i) begin
						rd_req_r <= 1'b0;
						rd_state <= tag_afull ? burst_pkg::RD_WAIT : burst_pkg::RD_CHECK;
					end
				end
				default: begin // RD_WAIT
					if (!tag_afull) begin
						rd_state <= burst_pkg::RD_CHECK;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rd_addr_r <= head_q.job.addr;
			push_job_r.id <= head_q.job.id;
			push_job_r.addr <= head_q.job.addr + BURST_BYTES;
			push_job_r.beats <= head_q.job.beats - 26'(`IOR_BURST_BEATS);
			if (head_q.job.beats > `IOR_BURST_BEATS) begin
				rd_len_r <= 8'(`IOR_BURST_BEATS - 1);
			end else begin
				rd_len_r <= head_q.job.beats[7:0] - 8'd1; // last burst of the job
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			tag_mem[tag_wr_ptr] <= head_q.job.id;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tag_wr_ptr <= '0;
			tag_rd_ptr <= '0;
			tag_count <= '0;
		end else begin
			if (take) begin
				tag_wr_ptr <= tag_wr_ptr + 1'b1;
			end
			if (tag_rd) begin
				tag_rd_ptr <= tag_rd_ptr + 1'b1;
			end
			tag_count <= tag_count + take - tag_rd;
		end
	end

	assign push_q.valid = push_valid_r;
	assign push_q.job = push_job_r;
	assign rd_req_o = rd_req_r;
	assign rd_len_o = rd_len_r;
	assign rd_addr_o = rd_addr_r;
	assign tag_o = tag_mem[tag_rd_ptr];
	assign tag_valid_o = (tag_count != '0);
	assign tags_empty_o = (tag_count == '0);

endmodule

`default_nettype wire

// File: source/burst_pkg.sv
// read burst types for the io_reader scheduler
// tag stored per burst in flight and the burst issue FSM encoding
`default_nettype none

package burst_pkg;

	typedef logic [15:0] tag_t; // job id of one burst

	typedef enum logic [1:0] {
		RD_START,
		RD_CHECK, // look at work queue head
		RD_PROCESS, // request held until ack
		RD_WAIT // tag fifo back-pressure
	} rd_state_e;

endpackage

`default_nettype wire

// File: source/io_reader_defines.svh
// io_reader configuration
// lane count, beat and burst geometry, queue depths and the idle hold time
// shared by the read scheduler RTL and its testbench
`ifndef IO_READER_DEFINES_SVH
`define IO_READER_DEFINES_SVH

`define IOR_NUM_LANES 3 // decompression lanes
`define IOR_LANE_W 2 // lane index and work count width

`define IOR_BEAT_BYTES 64 // bytes per read beat
`define IOR_BEAT_LOG 6 // log2 of beat size

`define IOR_BURST_BEATS 64 // one 4 KB burst

`define IOR_TAG_DEPTH 8 // bursts in flight
`define IOR_TAG_AFULL 6 // stop issuing at this level

`define IOR_PEND_DEPTH 8 // host job queue

`define IOR_DONE_HOLD 6 // quiet cycles before idle

`endif

// File: source/io_reader_top.sv
// io_reader top level
// read-side scheduler for a bank of decompression lanes: admits host jobs,
// splits them into 4 KB read bursts and routes returned beats to lanes
`timescale 1ns/1ns
`include "io_reader_defines.svh"
`default_nettype none

module io_reader_top (
	input logic clk,
	input logic rst_n,
	input logic start_i,
	output logic idle_o,
	input logic job_valid_i,
	input logic [15:0] job_id_i,
	input logic [63:0] src_addr_i,
	input logic [31:0] comp_len_i,
	output logic job_full_o,
	output logic rd_req_o,
	input logic rd_req_ack_i,
	output logic [7:0] rd_len_o,
	output logic [63:0] rd_addr_o,
	input logic [`IOR_BEAT_BYTES*8-1:0] rd_data_i,
	input logic rd_valid_i,
	input logic rd_last_i,
	output logic data_taken_o,
	input logic [`IOR_NUM_LANES-1:0] lane_afull_i,
	input logic [`IOR_NUM_LANES-1:0] lane_release_i,
	output logic [`IOR_BEAT_BYTES*8-1:0] lane_data_o,
	output logic [`IOR_NUM_LANES-1:0] lane_valid_o,
	output logic [`IOR_NUM_LANES-1:0] lane_busy_o,
	output logic [`IOR_NUM_LANES-1:0][15:0] lane_job_o
);

	logic [`IOR_LANE_W-1:0] work_count;
	logic tags_empty;
	burst_pkg::tag_t tag;
	logic tag_valid;
	logic tag_pop;

	job_if admit_q ();
	job_if head_q ();
	job_if push_q ();

	job_admit u_admit (
		.clk(clk),
		.rst_n(rst_n),
		.start_i(start_i),
		.job_valid_i(job_valid_i),
		.job_id_i(job_id_i),
		.src_addr_i(src_addr_i),
		.comp_len_i(comp_len_i),
		.job_full_o(job_full_o),
		.lane_release_i(lane_release_i),
		.work_count_i(work_count),
		.tags_empty_i(tags_empty),
		.idle_o(idle_o),
		.lane_busy_o(lane_busy_o),
		.lane_job_o(lane_job_o),
		.admit_q(admit_q.src)
	);

	work_queue u_work (
		.clk(clk),
		.rst_n(rst_n),
		.admit_q(admit_q.dst),
		.push_q(push_q.dst),
		.head_q(head_q.src),
		.count_o(work_count)
	);

	burst_issuer u_issue (
		.clk(clk),
		.rst_n(rst_n),
		.start_i(start_i),
		.head_q(head_q.dst),
		.push_q(push_q.src),
		.rd_req_o(rd_req_o),
		.rd_req_ack_i(rd_req_ack_i),
		.rd_len_o(rd_len_o),
		.rd_addr_o(rd_addr_o),
		.tag_o(tag),
		.tag_valid_o(tag_valid),
		.tag_pop_i(tag_pop),
		.tags_empty_o(tags_empty)
	);

	lane_router u_route (
		.clk(clk),
		.rst_n(rst_n),
		.rd_data_i(rd_data_i),
		.rd_valid_i(rd_valid_i),
		.rd_last_i(rd_last_i),
		.data_taken_o(data_taken_o),
		.lane_afull_i(lane_afull_i),
		.tag_i(tag),
		.tag_valid_i(tag_valid),
		.tag_pop_o(tag_pop),
		.lane_busy_i(lane_busy_o),
		.lane_job_i(lane_job_o),
		.lane_data_o(lane_data_o),
		.lane_valid_o(lane_valid_o)
	);

endmodule

`default_nettype wire

// File: source/job_admit.sv
// job admission
// buffers host jobs in a pending fifo, converts the byte length to beats,
// assigns each job the lowest free lane and hands it to the work queue;
// also owns the lane table and the run/idle control
`timescale 1ns/1ns
`include "io_reader_defines.svh"
`default_nettype none

module job_admit (
	input logic clk,
	input logic rst_n,
	input logic start_i,
	input logic job_valid_i,
	input logic [15:0] job_id_i,
	input logic [63:0] src_addr_i,
	input logic [31:0] comp_len_i,
	output logic job_full_o,
	input logic [`IOR_NUM_LANES-1:0] lane_release_i,
	input logic [`IOR_LANE_W-1:0] work_count_i,
	input logic tags_empty_i,
	output logic idle_o,
	output logic [`IOR_NUM_LANES-1:0] lane_busy_o,
	output logic [`IOR_NUM_LANES-1:0][15:0] lane_job_o,
	job_if.src admit_q
);

	localparam int PEND_AW = $clog2(`IOR_PEND_DEPTH);

	logic [111:0] pend_mem [`IOR_PEND_DEPTH];
	logic [111:0] pend_dout; // {id, addr, byte length}
	logic [PEND_AW-1:0] pend_wr_ptr;
	logic [PEND_AW-1:0] pend_rd_ptr;
	logic [PEND_AW:0] pend_count;
	logic pend_wr;
	logic pend_rd;
	logic pend_empty;
	job_pkg::admit_state_e adm_state;
	job_pkg::run_state_e run_state;
	job_pkg::job_t job_r;
	logic admit_valid_r;
	logic [`IOR_LANE_W-1:0] free_lane;
	logic [`IOR_LANE_W-1:0] pick_lane;
	logic any_free;
	logic quiet;
	logic [`IOR_DONE_HOLD-1:0] quiet_hist;

	assign pend_wr = job_valid_i & (pend_count != `IOR_PEND_DEPTH);
	assign pend_rd = (adm_state == job_pkg::ADM_FETCH);
	assign pend_empty = (pend_count == '0);
	assign job_full_o = (pend_count >= `IOR_PEND_DEPTH - 2);

	always_ff @(posedge clk) begin
		if (pend_wr) begin
			pend_mem[pend_wr_ptr] <= {job_id_i, src_addr_i, comp_len_i};
		end
		if (pend_rd) begin
			pend_dout <= pend_mem[pend_rd_ptr]; // registered read port
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pend_wr_ptr <= '0;
			pend_rd_ptr <= '0;
			pend_count <= '0;
		end else begin
			if (pend_wr) begin
				pend_wr_ptr <= pend_wr_ptr + 1'b1;
			end
			if (pend_rd) begin
				pend_rd_ptr <= pend_rd_ptr + 1'b1;
			end
			pend_count <= pend_count + pend_wr - pend_rd;
		end
	end

	// lowest lane that is not busy
	always_comb begin
		any_free = 1'b0;
		free_lane = '0;
		for (int i = `IOR_NUM_LANES - 1; i >= 0; i--) begin
			if (!lane_busy_o[i]) begin
				any_free = 1'b1;
				free_lane = `IOR_LANE_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			adm_state <= job_pkg::ADM_IDLE;
			admit_valid_r <= 1'b0;
		end else begin
			case (adm_state)
				job_pkg::ADM_IDLE: begin
					if (start_i) begin
						adm_state <= job_pkg::ADM_WAIT;
					end
				end
				job_pkg::ADM_WAIT: begin
					if (!pend_empty) begin
						adm_state <= job_pkg::ADM_FETCH;
					end
				end
				job_pkg::ADM_FETCH: adm_state <= job_pkg::ADM_LOAD;
				job_pkg::ADM_LOAD: begin
					job_r.id <= pend_dout[111:96];
					job_r.addr <= pend_dout[95:32];
					job_r.beats <= pend_dout[31:`IOR_BEAT_LOG]
						+ 26'(|pend_dout[`IOR_BEAT_LOG-1:0]); // round up to beats
					adm_state <= job_pkg::ADM_PICK;
				end
				job_pkg::ADM_PICK: begin
					if (any_free && (work_count_i < `IOR_NUM_LANES - 1)) begin
						pick_lane <= free_lane;
						admit_valid_r <= 1'b1;
						adm_state <= job_pkg::ADM_PUSH;
					end
				end
				job_pkg::ADM_PUSH: begin
					if (admit_q.ready) begin // push-back may hold us off
						admit_valid_r <= 1'b0;
						adm_state <= job_pkg::ADM_WAIT;
					end
				end
				default: adm_state <= job_pkg::ADM_IDLE;
			endcase
		end
	end

	assign admit_q.valid = admit_valid_r;
	assign admit_q.job = job_r;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lane_busy_o <= '0;
		end else begin
			lane_busy_o <= lane_busy_o & ~lane_release_i;
			if (admit_q.valid && admit_q.ready) begin
				lane_busy_o[pick_lane] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (admit_q.valid && admit_q.ready) begin
			lane_job_o[pick_lane] <= job_r.id;
		end
	end

	// nothing pending, queued, in flight or owned by a lane
	assign quiet = pend_empty & (work_count_i == '0) & tags_empty_i & ~|lane_busy_o
		& (adm_state inside {job_pkg::ADM_IDLE, job_pkg::ADM_WAIT});

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_state <= job_pkg::RUN_IDLE;
			quiet_hist <= '0;
		end else begin
			quiet_hist <= {quiet_hist[`IOR_DONE_HOLD-2:0], quiet};
			case (run_state)
				job_pkg::RUN_IDLE: begin
					if (start_i) begin
						run_state <= job_pkg::RUN_BUSY;
						quiet_hist <= '0; // history restarts with the run
					end
				end
				default: begin
					if (&quiet_hist) begin
						run_state <= job_pkg::RUN_IDLE;
					end
				end
			endcase
		end
	end

	assign idle_o = (run_state == job_pkg::RUN_IDLE);

endmodule

`default_nettype wire

// File: source/job_if.sv
// job record channel
// carries one job between the admit FSM, the work queue and the burst issuer
// valid comes from the source, ready from the destination
`timescale 1ns/1ns
`default_nettype none

interface job_if;

	job_pkg::job_t job;
	logic valid;
	logic ready; // level or pop pulse, depending on the link

	modport src (
		output job,
		output valid,
		input ready
	);

	modport dst (
		input job,
		input valid,
		output ready
	);

endinterface

`default_nettype wire

// File: source/job_pkg.sv
// job types for the io_reader scheduler
// one job record as it moves through admission and the work queue,
// plus the admit and run FSM encodings
`default_nettype none

package job_pkg;

	typedef struct packed {
		logic [15:0] id; // host job id
		logic [63:0] addr; // next source address
		logic [25:0] beats; // beats still to read
	} job_t;

	typedef enum logic [2:0] {
		ADM_IDLE,
		ADM_WAIT, // pending fifo empty
		ADM_FETCH,
		ADM_LOAD,
		ADM_PICK, // wait for a free lane
		ADM_PUSH
	} admit_state_e;

	typedef enum logic {RUN_IDLE, RUN_BUSY} run_state_e;

endpackage

`default_nettype wire

// File: source/lane_router.sv
// read data router
// registers input flow control, buffers each accepted beat and forwards it
// to the busy lane whose job id matches the tag of the current burst
`timescale 1ns/1ns
`include "io_reader_defines.svh"
`default_nettype none

module lane_router (
	input logic clk,
	input logic rst_n,
	input logic [`IOR_BEAT_BYTES*8-1:0] rd_data_i,
	input logic rd_valid_i,
	input logic rd_last_i,
	output logic data_taken_o,
	input logic [`IOR_NUM_LANES-1:0] lane_afull_i,
	input burst_pkg::tag_t tag_i,
	input logic tag_valid_i,
	output logic tag_pop_o,
	input logic [`IOR_NUM_LANES-1:0] lane_busy_i,
	input logic [`IOR_NUM_LANES-1:0][15:0] lane_job_i,
	output logic [`IOR_BEAT_BYTES*8-1:0] lane_data_o,
	output logic [`IOR_NUM_LANES-1:0] lane_valid_o
);

	logic data_taken_r;
	logic beat_valid_r;
	logic beat_last_r;
	logic [`IOR_BEAT_BYTES*8-1:0] beat_data_r;
	logic [`IOR_BEAT_BYTES*8-1:0] lane_data_r;
	logic [`IOR_NUM_LANES-1:0] lane_valid_r;
	logic [`IOR_NUM_LANES-1:0] lane_hit;

	always_comb begin
		for (int i = 0; i < `IOR_NUM_LANES; i++) begin
			lane_hit[i] = lane_busy_i[i] & (lane_job_i[i] == tag_i);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_taken_r <= 1'b0;
			beat_valid_r <= 1'b0;
			beat_last_r <= 1'b0;
			lane_valid_r <= '0;
		end else begin
			data_taken_r <= ~|lane_afull_i; // any almost full lane stops input
			beat_valid_r <= rd_valid_i & data_taken_r;
			beat_last_r <= rd_valid_i & rd_last_i & data_taken_r;
			lane_valid_r <= {`IOR_NUM_LANES{beat_valid_r & tag_valid_i}} & lane_hit;
		end
	end

	always_ff @(posedge clk) begin
		beat_data_r <= rd_data_i;
		lane_data_r <= beat_data_r;
	end

	assign tag_pop_o = beat_valid_r & beat_last_r; // burst done, next tag
	assign data_taken_o = data_taken_r;
	assign lane_data_o = lane_data_r;
	assign lane_valid_o = lane_valid_r;

endmodule

`default_nettype wire

// File: source/work_queue.sv
// work queue of active jobs
// small circular buffer, one entry per lane; a job pushed back by the
// burst issuer wins the write port over a new admission
`timescale 1ns/1ns
`include "io_reader_defines.svh"
`default_nettype none

module work_queue (
	input logic clk,
	input logic rst_n,
	job_if.dst admit_q,
	job_if.dst push_q,
	job_if.src head_q,
	output logic [`IOR_LANE_W-1:0] count_o
);

	job_pkg::job_t q_mem [`IOR_NUM_LANES];
	job_pkg::job_t wr_job;
	logic [`IOR_LANE_W-1:0] wr_ptr;
	logic [`IOR_LANE_W-1:0] rd_ptr;
	logic [`IOR_LANE_W-1:0] count;
	logic wr_en;
	logic pop;

	assign push_q.ready = 1'b1; // a remainder is never refused
	assign admit_q.ready = ~push_q.valid & (count != `IOR_NUM_LANES);

	assign wr_en = push_q.valid | (admit_q.valid & admit_q.ready);
	assign wr_job = push_q.valid ? push_q.job : admit_q.job;
	assign pop = head_q.ready & head_q.valid;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			q_mem[wr_ptr] <= wr_job;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == `IOR_NUM_LANES - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == `IOR_NUM_LANES - 1) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + wr_en - pop;
		end
	end

	assign head_q.valid = (count != '0);
	assign head_q.job = q_mem[rd_ptr];
	assign count_o = count;

endmodule

`default_nettype wire

// File: verif/io_reader_tb.sv
// testbench for the io_reader read scheduler
// feeds host jobs, models the read memory and the decompression lanes,
// and checks burst splitting, request hold, routing, flow control and idle
`timescale 1ns/1ns
`include "io_reader_defines.svh"
`default_nettype none

module io_reader_tb;

	localparam int NUM_JOBS = 12;
	localparam int BEAT_W = `IOR_BEAT_BYTES * 8;
	localparam int LIMIT_CYCLES = NUM_JOBS * 200 + 2000;
	localparam int CAT_REQ = 0;
	localparam int CAT_ROUTE = 1;
	localparam int CAT_FLOW = 2;
	localparam int CAT_RUN = 3;

	typedef struct packed {
		logic [31:0] due; // monitor cycle of delivery
		logic [BEAT_W-1:0] data;
	} beat_exp_t;

	typedef struct packed {
		logic [63:0] addr;
		logic [7:0] len;
	} burst_t;

	logic clk;
	logic rst_n;
	logic start_i;
	logic idle_o;
	logic job_valid_i;
	logic [15:0] job_id_i;
	logic [63:0] src_addr_i;
	logic [31:0] comp_len_i;
	logic job_full_o;
	logic rd_req_o;
	logic rd_req_ack_i;
	logic [7:0] rd_len_o;
	logic [63:0] rd_addr_o;
	logic [BEAT_W-1:0] rd_data_i;
	logic rd_valid_i;
	logic rd_last_i;
	logic data_taken_o;
	logic [`IOR_NUM_LANES-1:0] lane_afull_i;
	logic [`IOR_NUM_LANES-1:0] lane_release_i;
	logic [BEAT_W-1:0] lane_data_o;
	logic [`IOR_NUM_LANES-1:0] lane_valid_o;
	logic [`IOR_NUM_LANES-1:0] lane_busy_o;
	logic [`IOR_NUM_LANES-1:0][15:0] lane_job_o;

	logic [15:0] job_id [NUM_JOBS];
	logic [63:0] job_src [NUM_JOBS];
	logic [31:0] job_len [NUM_JOBS]; // bytes
	int job_beats [NUM_JOBS];
	int job_bursts [NUM_JOBS];
	int req_count [NUM_JOBS]; // bursts seen so far per job
	int lane_cnt [`IOR_NUM_LANES];
	int errs [4];
	int total_beats;
	int delivered;
	int cycle;
	bit running;
	bit [`IOR_NUM_LANES-1:0] release_req;
	bit prev_on;
	bit prev_req;
	bit prev_ack;
	bit [`IOR_NUM_LANES-1:0] prev_afull;
	bit [`IOR_NUM_LANES-1:0] prev_busy;
	int jobs_in; // jobs written into the pending fifo
	int admitted; // lane assignments seen on lane_busy_o
	logic [7:0] prev_len;
	logic [63:0] prev_addr;
	beat_exp_t exp_q [$];
	burst_t burst_q [$]; // acked bursts waiting for data

	io_reader_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.start_i(start_i),
		.idle_o(idle_o),
		.job_valid_i(job_valid_i),
		.job_id_i(job_id_i),
		.src_addr_i(src_addr_i),
		.comp_len_i(comp_len_i),
		.job_full_o(job_full_o),
		.rd_req_o(rd_req_o),
		.rd_req_ack_i(rd_req_ack_i),
		.rd_len_o(rd_len_o),
		.rd_addr_o(rd_addr_o),
		.rd_data_i(rd_data_i),
		.rd_valid_i(rd_valid_i),
		.rd_last_i(rd_last_i),
		.data_taken_o(data_taken_o),
		.lane_afull_i(lane_afull_i),
		.lane_release_i(lane_release_i),
		.lane_data_o(lane_data_o),
		.lane_valid_o(lane_valid_o),
		.lane_busy_o(lane_busy_o),
		.lane_job_o(lane_job_o)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic assert_ok(input bit ok, input int cat, input string msg);
		assert (ok) else begin
			errs[cat]++;
			$display("ERR %0t: %s", $time, msg);
		end
	endtask

	// job index whose source range holds addr, -1 if none
	function automatic int find_job(input logic [63:0] addr);
		int idx;
		idx = -1;
		for (int i = 0; i < NUM_JOBS; i++) begin
			if (addr >= job_src[i] && addr < job_src[i] + 64'(job_beats[i]) * 64) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	// beat payload: burst address and beat index, upper part mixes both
	function automatic logic [BEAT_W-1:0] beat_data(input logic [63:0] addr, input int beat);
		return {{6{addr ^ 64'(beat)}}, addr, 64'(beat)};
	endfunction

	task automatic build_jobs();
		total_beats = 0;
		for (int i = 0; i < NUM_JOBS; i++) begin
			job_id[i] = 16'h0a00 + 16'(i);
			job_src[i] = (64'(i + 1) << 32) | (64'($urandom_range(0, 1023)) << 6);
			if (i == 0) begin
				job_len[i] = 32'd4096; // exactly one burst
			end else if (i == 1) begin
				job_len[i] = 32'd4097; // spills one beat into a second burst
			end else begin
				job_len[i] = 32'($urandom_range(1, 200 * `IOR_BEAT_BYTES));
			end
			job_beats[i] = (job_len[i] + `IOR_BEAT_BYTES - 1) / `IOR_BEAT_BYTES;
			job_bursts[i] = (job_beats[i] + `IOR_BURST_BEATS - 1) / `IOR_BURST_BEATS;
			total_beats += job_beats[i];
		end
	endtask

	// burst k of a job starts at src + 4096*k, only the last one is short
	task automatic check_request(input logic [63:0] addr, input logic [7:0] len);
		int j;
		int k;
		int exp_len;
		logic [63:0] exp_addr;
		j = find_job(addr);
		assert_ok(j >= 0, CAT_REQ, $sformatf("read request at %h matches no job", addr));
		if (j >= 0) begin
			k = req_count[j];
			exp_addr = job_src[j] + 64'(k) * 64'(`IOR_BURST_BEATS * `IOR_BEAT_BYTES);
			exp_len = `IOR_BURST_BEATS - 1;
			if (k == job_bursts[j] - 1) begin
				exp_len = job_beats[j] - `IOR_BURST_BEATS * k - 1;
			end
			assert_ok(k < job_bursts[j] && addr == exp_addr && len == 8'(exp_len), CAT_REQ,
				$sformatf("job %h burst %0d at %h len %0d, expected %h len %0d",
				job_id[j], k, addr, len, exp_addr, exp_len));
			req_count[j]++;
		end
	endtask

	task automatic check_reset_outputs();
		assert_ok(!rd_req_o && !data_taken_o && lane_valid_o == '0 && idle_o, CAT_RUN,
			$sformatf("reset outputs rd_req %b data_taken %b lane_valid %b idle %b",
			rd_req_o, data_taken_o, lane_valid_o, idle_o));
	endtask

	task automatic print_counts();
		$display("errors: request %0d, routing %0d, flow %0d, run %0d",
			errs[CAT_REQ], errs[CAT_ROUTE], errs[CAT_FLOW], errs[CAT_RUN]);
	endtask

	// all checks sample mid cycle, inputs change 1 ns after the rising edge
	always @(negedge clk) begin : monitor
		beat_exp_t ent;
		int j;
		int lane;
		int held;
		release_req = '0;
		if (rst_n) begin
			cycle++;
			if (rd_req_o && !(prev_on && prev_req)) begin
				check_request(rd_addr_o, rd_len_o);
			end
			if (prev_on && prev_req && prev_ack) begin
				assert_ok(!rd_req_o, CAT_REQ, "rd_req_o still high after its ack");
			end else if (prev_on && prev_req) begin
				assert_ok(rd_req_o && rd_len_o == prev_len && rd_addr_o == prev_addr, CAT_REQ,
					"read request changed before its ack");
			end
			if (prev_on) begin
				assert_ok(data_taken_o == ~|prev_afull, CAT_FLOW,
					$sformatf("data_taken_o %b after lane_afull_i %b", data_taken_o, prev_afull));
			end
			// the pending fifo holds the jobs not yet on a lane, less the one
			// that the admit FSM may already have read
			admitted += $countones(lane_busy_o & ~prev_busy);
			held = jobs_in - admitted;
			if (held >= `IOR_PEND_DEPTH) begin
				assert_ok(job_full_o, CAT_FLOW,
					$sformatf("job_full_o low with %0d jobs waiting", held));
			end else if (held == 0) begin
				assert_ok(!job_full_o, CAT_FLOW, "job_full_o high with no job waiting");
			end
			if (job_valid_i) begin
				jobs_in++; // written on the next edge
			end
			if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
				ent = exp_q.pop_front();
				lane = 0;
				for (int i = 0; i < `IOR_NUM_LANES; i++) begin
					if (lane_valid_o[i]) begin
						lane = i;
					end
				end
				j = find_job(ent.data[127:64]);
				assert_ok($onehot(lane_valid_o) && lane_data_o == ent.data, CAT_ROUTE,
					$sformatf("beat %0d of burst %h: lane_valid_o %b or data wrong",
					ent.data[63:0], ent.data[127:64], lane_valid_o));
				if (j >= 0) begin
					assert_ok(lane_job_o[lane] == job_id[j], CAT_ROUTE,
						$sformatf("job %h beat on lane %0d owned by %h",
						job_id[j], lane, lane_job_o[lane]));
					lane_cnt[lane]++;
					if (lane_cnt[lane] == job_beats[j]) begin
						release_req[lane] = 1'b1; // whole job received
						lane_cnt[lane] = 0;
					end
				end
				delivered++;
			end else begin
				assert_ok(lane_valid_o == '0, CAT_ROUTE,
					$sformatf("lane_valid_o %b with no beat due", lane_valid_o));
			end
			if (rd_valid_i && data_taken_o) begin
				exp_q.push_back({32'(cycle + 2), rd_data_i}); // two edges to the lane
			end
			if (running && idle_o) begin
				assert_ok(delivered == total_beats && lane_busy_o == '0, CAT_RUN,
					$sformatf("idle_o high with %0d of %0d beats delivered, busy %b",
					delivered, total_beats, lane_busy_o));
			end
		end
		prev_on = rst_n;
		prev_req = rd_req_o;
		prev_ack = rd_req_ack_i;
		prev_afull = lane_afull_i;
		prev_busy = lane_busy_o;
		prev_len = rd_len_o;
		prev_addr = rd_addr_o;
	end

	// memory side: ack each request after a short random delay
	initial begin : request_responder
		burst_t cur;
		rd_req_ack_i = 1'b0;
		forever begin
			@(negedge clk);
			if (rd_req_o) begin
				cur.addr = rd_addr_o;
				cur.len = rd_len_o;
				repeat ($urandom_range(0, 3)) @(negedge clk);
				@(posedge clk);
				#1 rd_req_ack_i = 1'b1;
				@(posedge clk);
				#1 rd_req_ack_i = 1'b0;
				burst_q.push_back(cur);
			end
		end
	end

	// returns the acked bursts in order, holding a beat until it is taken
	initial begin : data_responder
		burst_t cur;
		int beat;
		rd_valid_i = 1'b0;
		rd_last_i = 1'b0;
		rd_data_i = '0;
		forever begin
			if (burst_q.size() == 0) begin
				rd_valid_i = 1'b0;
				rd_last_i = 1'b0;
				@(posedge clk);
				#1;
			end else begin
				cur = burst_q.pop_front();
				beat = 0;
				while (beat <= int'(cur.len)) begin
					rd_valid_i = 1'b1;
					rd_last_i = (beat == int'(cur.len));
					rd_data_i = beat_data(cur.addr, beat);
					@(negedge clk);
					if (data_taken_o) begin
						beat++;
					end
					@(posedge clk);
					#1;
				end
			end
		end
	end

	initial begin : lane_model
		lane_afull_i = '0;
		lane_release_i = '0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clk);
			#1;
			lane_release_i = release_req;
			for (int i = 0; i < `IOR_NUM_LANES; i++) begin
				lane_afull_i[i] = ($urandom_range(0, 15) == 0); // random back-pressure
			end
		end
	end

	initial begin : watchdog
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles before the run completed", LIMIT_CYCLES);
		print_counts();
		$display("TESTS FAILED");
		$finish;
	end

	initial begin : main_seq
		int j;
		rst_n = 1'b0;
		start_i = 1'b0;
		job_valid_i = 1'b0;
		job_id_i = '0;
		src_addr_i = '0;
		comp_len_i = '0;
		void'($urandom(32'h6127));
		build_jobs();
		repeat (2) begin
			@(negedge clk);
			check_reset_outputs();
		end
		@(posedge clk);
		#1 rst_n = 1'b1; // three edges in reset
		@(negedge clk);
		check_reset_outputs();
		@(posedge clk);
		#1 start_i = 1'b1;
		@(negedge clk);
		assert_ok(idle_o, CAT_RUN, "idle_o fell before start was sampled");
		@(posedge clk);
		#1 start_i = 1'b0;
		@(negedge clk);
		assert_ok(!idle_o, CAT_RUN, "idle_o still high one edge after start");
		running = 1'b1;
		j = 0;
		while (j < NUM_JOBS) begin
			@(posedge clk);
			#1;
			if (!job_full_o) begin
				job_valid_i = 1'b1;
				job_id_i = job_id[j];
				src_addr_i = job_src[j];
				comp_len_i = job_len[j];
				j++;
			end else begin
				job_valid_i = 1'b0;
			end
		end
		@(posedge clk);
		#1 job_valid_i = 1'b0;
		while (delivered < total_beats) begin
			@(negedge clk);
		end
		while (!idle_o) begin
			@(negedge clk);
		end
		for (int i = 0; i < NUM_JOBS; i++) begin
			assert_ok(req_count[i] == job_bursts[i], CAT_REQ,
				$sformatf("job %h issued %0d bursts, expected %0d",
				job_id[i], req_count[i], job_bursts[i]));
		end
		print_counts();
		if (errs[0] + errs[1] + errs[2] + errs[3] == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
